/* Bender.yml */
package:
  name: ramio

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ramio_pkg.sv
      - hw/word_ram.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/ramio.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/clk_gen.sv
      - dv/ramio_properties.sv
      - dv/ramio_tb.sv

/* dv/clk_gen.sv */
/* clk_gen
   testbench clock, 10 ns period, and active-low reset held for the first cycles */
`default_nettype none

module clk_gen #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);  // release away from the active edge
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* dv/ramio_golden.txt */
# op addr wtype rtype data expected, all hex
# op: W write, R read, B read with no gap, T expect uart_tx byte, X send uart_rx byte
W 00000010 0 0 11223344 00000000
W 00000010 3 0 11223344 00000000
W 00000010 1 0 000000AA 00000000
W 00000011 1 0 00000077 00000000
W 00000012 1 0 00000066 00000000
W 00000013 1 0 000000BB 00000000
R 00000010 0 3 00000000 BB6677AA
W 00000012 2 0 0000CCDD 00000000
W 00000010 2 0 00005566 00000000
R 00000010 0 3 00000000 CCDD5566
W 00000020 3 0 80F17F82 00000000
R 00000020 0 5 00000000 FFFFFF82
R 00000021 0 1 00000000 0000007F
R 00000022 0 5 00000000 FFFFFFF1
R 00000023 0 1 00000000 00000080
R 00000022 0 6 00000000 FFFF80F1
R 00000020 0 2 00000000 00007F82
R 00000021 0 2 00000000 00000000
R 00000022 0 3 00000000 00000000
W 00000021 3 0 DEADBEEF 00000000
W 00000023 2 0 0000FFFF 00000000
R 00000020 0 3 00000000 80F17F82
W 00000FFC 3 0 12345678 00000000
W FFFFFFFF 1 0 0000003A 0000000A
R FFFFFFFF 0 1 00000000 00000000
R 00000FFC 0 3 00000000 12345678
W FFFFFFFE 1 0 000000C3 00000000
R FFFFFFFE 0 1 00000000 000000C3
R FFFFFFFE 0 5 00000000 FFFFFFC3
T 00000000 0 0 00000000 000000C3
X 00000000 0 0 000000A5 00000000
R FFFFFFFD 0 5 00000000 FFFFFFA5
R FFFFFFFD 0 1 00000000 00000000
X 00000000 0 0 0000003C 00000000
R FFFFFFFD 0 1 00000000 0000003C
R 00000010 0 3 00000000 CCDD5566
B 00000020 0 3 00000000 80F17F82
B 00000FFC 0 3 00000000 12345678
B 00000013 0 5 00000000 FFFFFFCC

/* dv/ramio_properties.sv */
/* ramio_properties
   concurrent checks on ramio read latency, I/O write gating, UART idle level and LED reset */
`default_nettype none

`include "ramio_params.svh"

module ramio_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              enable,
  input ramio_pkg::rtype_t read_type,
  input ramio_pkg::addr_t  address,
  input logic              data_out_ready,
  input ramio_pkg::led_t   led,
  input logic              uart_tx,
  input ramio_pkg::be_t    ram_be,
  input logic              tx_busy
);
  timeunit 1ns;
  timeprecision 100ps;

  logic        rd_req;          // strobe carrying a read
  logic        is_io;
  int unsigned fail_count = 0;  // polled by the testbench top

  assign rd_req = enable && read_type != '0;
  assign is_io  = address == `RAMIO_ADDR_LED || address == `RAMIO_ADDR_UART_OUT ||
                  address == `RAMIO_ADDR_UART_IN;

  // ready exactly one clock after a read strobe, and never otherwise
  ready_after_read: assert property (@(posedge clk) disable iff (!rst_n)
    rd_req |=> data_out_ready)
    else begin
      $error("data_out_ready missing one cycle after a read strobe");
      fail_count++;
    end

  no_ready_without_read: assert property (@(posedge clk) disable iff (!rst_n)
    !rd_req |=> !data_out_ready)
    else begin
      $error("data_out_ready high without a read strobe the cycle before");
      fail_count++;
    end

  io_no_ram_write: assert property (@(posedge clk) disable iff (!rst_n)
    is_io |-> ram_be == '0)
    else begin
      $error("RAM byte enables active on an I/O address");
      fail_count++;
    end

  tx_idle_mark: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> uart_tx)
    else begin
      $error("uart_tx low while the transmitter is idle");
      fail_count++;
    end

  led_reset_value: assert property (@(posedge clk) $rose(rst_n) |-> led == '1)
    else begin
      $error("led not all ones in the first cycle after reset");
      fail_count++;
    end

endmodule

bind ramio ramio_properties u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .enable        (enable),
  .read_type     (read_type),
  .address       (address),
  .data_out_ready(data_out_ready),
  .led           (led),
  .uart_tx       (uart_tx),
  .ram_be        (ram_be),
  .tx_busy       (tx_busy)
);

`default_nettype wire

/* dv/ramio_tb.sv */
/* ramio_tb
   golden-file driven testbench for the load/store port
   covers RAM lane steering, read extension, LED and both UART directions */
`default_nettype none

`include "ramio_params.svh"

module ramio_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ramio_pkg::*;

  localparam int    CPB    = `RAMIO_CLKS_PER_BIT;
  localparam string GOLDEN = "dv/ramio_golden.txt";

  logic   clk;
  logic   rst_n;
  logic   enable;
  wtype_t write_type;
  rtype_t read_type;
  addr_t  address;
  data_t  data_in;
  data_t  data_out;
  logic   data_out_ready;
  led_t   led;
  logic   uart_tx;
  logic   uart_rx;

  // operations from the golden file, one entry per line
  byte    op_q[$];
  addr_t  addr_q[$];
  wtype_t wt_q[$];
  rtype_t rt_q[$];
  data_t  data_q[$];
  data_t  exp_q[$];

  byte_t       tx_bytes[$];        // frames caught on uart_tx, oldest first
  logic        pending_valid;      // read in flight, ready due at next falling edge
  data_t       pending_exp;
  addr_t       pending_addr;
  logic        held_valid;         // a read has completed, data_out must hold it
  data_t       held_exp;
  addr_t       held_addr;
  logic [15:0] lfsr   = 16'd40151;
  int          cycles = 0;
  int          limit  = 0;         // 0 until the golden file is loaded

  clk_gen u_clk (
    .clk  (clk),
    .rst_n(rst_n)
  );

  ramio UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .write_type    (write_type),
    .read_type     (read_type),
    .address       (address),
    .data_in       (data_in),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .led           (led),
    .uart_tx       (uart_tx),
    .uart_rx       (uart_rx)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input addr_t a);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: read of %h gave %h, expected %h",
                          $time, a, got, exp));
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: uart_tx frame carried %h, expected %h",
                          $time, got, exp));
    end
  endtask

  task automatic check_led(input led_t got, input led_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: led is %h, expected %h", $time, got, exp));
    end
  endtask

  // one clock, checked at the falling edge where registered outputs are settled
  task automatic tick();
    @(negedge clk);
    if (pending_valid) begin
      if (data_out_ready !== 1'b1) begin
        abort_run($sformatf("no data_out_ready one cycle after the read of %h",
                            pending_addr));
      end
      check_data(data_out, pending_exp, pending_addr);
      held_valid = 1'b1;  // value stays on data_out until the next read
      held_exp   = pending_exp;
      held_addr  = pending_addr;
    end else if (data_out_ready !== 1'b0) begin
      abort_run("data_out_ready pulsed with no read in flight");
    end else if (held_valid) begin
      check_data(data_out, held_exp, held_addr);
    end
    pending_valid = 1'b0;
  endtask

  // single-cycle strobe, driven at a falling edge
  task automatic access(input addr_t a, input wtype_t w, input rtype_t r,
                        input data_t d, input data_t e);
    enable        = 1'b1;
    write_type    = w;
    read_type     = r;
    address       = a;
    data_in       = d;
    pending_valid = (r != '0);  // checked by the next tick
    pending_exp   = e;
    pending_addr  = a;
    tick();
    enable     = 1'b0;
    write_type = '0;
    read_type  = '0;
  endtask

  task automatic draw_gap(output int gap);
    gap = 0;
    repeat (2) begin  // two bits, one LFSR step each
      lfsr = lfsr_next(lfsr);
      gap  = (gap << 1) | lfsr[0];
    end
  endtask

  // 8N1 frame into uart_rx, then one idle bit so the receiver can finish
  task automatic send_frame(input byte_t b);
    uart_rx = 1'b0;
    repeat (CPB) tick();
    for (int i = 0; i < 8; i++) begin
      uart_rx = b[i];  // LSB first
      repeat (CPB) tick();
    end
    uart_rx = 1'b1;
    repeat (2 * CPB) tick();
  endtask

  // runs in the monitor process, so waits on edges directly
  task automatic capture_frame(output byte_t b);
    @(negedge uart_tx);
    repeat (CPB / 2) @(negedge clk);  // middle of start bit
    if (uart_tx !== 1'b0) abort_run("uart_tx start bit did not stay low to its center");
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge clk);
      b[i] = uart_tx;
    end
    repeat (CPB) @(negedge clk);
    if (uart_tx !== 1'b1) abort_run("uart_tx stop bit was low");
  endtask

  task automatic expect_tx(input byte_t exp);
    wait (tx_bytes.size() != 0);
    tick();  // back onto the falling edge
    check_byte(tx_bytes.pop_front(), exp);
  endtask

  task automatic load_golden();
    int          fd;
    string       line;
    byte         op;
    logic [31:0] a, w, r, d, e;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0) abort_run({"could not open ", GOLDEN});
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // blank or column note
      if ($sscanf(line, "%c %h %h %h %h %h", op, a, w, r, d, e) != 6) begin
        abort_run({"malformed line in golden file: ", line});
      end
      op_q.push_back(op);
      addr_q.push_back(addr_t'(a));
      wt_q.push_back(wtype_t'(w));
      rt_q.push_back(rtype_t'(r));
      data_q.push_back(data_t'(d));
      exp_q.push_back(data_t'(e));
    end
    $fclose(fd);
  endtask

  task automatic run_op(input int i);
    int gap;
    if (op_q[i] != "B") begin  // B follows the previous access with no gap
      draw_gap(gap);
      repeat (gap) tick();
    end
    case (op_q[i])
      "W", "R", "B": begin
        access(addr_q[i], wt_q[i], rt_q[i], data_q[i], exp_q[i]);
        if (op_q[i] == "W" && addr_q[i] == `RAMIO_ADDR_LED) begin
          check_led(led, led_t'(exp_q[i]));
        end
      end
      "T": expect_tx(byte_t'(exp_q[i]));
      "X": send_frame(byte_t'(data_q[i]));
      default: abort_run($sformatf("unknown opcode %c in golden file", op_q[i]));
    endcase
  endtask

  // deserializer, queues every frame the DUT sends
  initial begin : tx_monitor
    byte_t b;
    wait (rst_n === 1'b1);
    forever begin
      capture_frame(b);
      tx_bytes.push_back(b);
    end
  end

  // run limit and bound assertion status
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      abort_run($sformatf("timeout after %0d cycles, the test did not finish", cycles));
    end else if (UUT.u_props.fail_count != 0) begin
      abort_run("a bound assertion on the DUT failed");
    end
  end

  initial begin
    enable        = 1'b0;
    write_type    = '0;
    read_type     = '0;
    address       = '0;
    data_in       = '0;
    uart_rx       = 1'b1;  // line idles at mark
    pending_valid = 1'b0;
    held_valid    = 1'b0;
    load_golden();
    // worst op is a full frame plus slack, reset cycles on top
    limit = op_q.size() * (12 * CPB + 8) + 20;
    wait (rst_n === 1'b1);
    tick();
    check_led(led, '1);  // LEDs off out of reset
    foreach (op_q[i]) run_op(i);
    repeat (4) tick();
    if (tx_bytes.size() != 0) begin
      abort_run("uart_tx sent a frame that no golden line expected");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/ramio_pkg.sv
hw/word_ram.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/ramio.sv
dv/clk_gen.sv
dv/ramio_properties.sv
dv/ramio_tb.sv

/* hw/ramio.sv */
/* ramio
   load/store port: routes strobed accesses to word RAM or to LED and UART registers,
   steers write lanes and sign/zero extends read data with one clock latency */
`default_nettype none

`include "ramio_params.svh"

module ramio (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  ramio_pkg::wtype_t write_type,
  input  ramio_pkg::rtype_t read_type,
  input  ramio_pkg::addr_t  address,
  input  ramio_pkg::data_t  data_in,
  output ramio_pkg::data_t  data_out,
  output logic              data_out_ready,
  output ramio_pkg::led_t   led,
  output logic              uart_tx,
  input  logic              uart_rx
);
  import ramio_pkg::*;

  // size field of wtype_t / rtype_t
  localparam logic [1:0] SZ_BYTE = 2'd1;
  localparam logic [1:0] SZ_HALF = 2'd2;
  localparam logic [1:0] SZ_WORD = 2'd3;

  logic      is_led, is_uart_out, is_uart_in, is_io;
  logic      wr_led, wr_uart_out, rd_uart_in;
  logic      rd_fire;

  logic      ram_en;
  be_t       ram_be;
  ram_addr_t ram_addr;
  data_t     ram_wdata, ram_rdata;

  logic      tx_start, tx_busy;
  byte_t     tx_data, tx_sending;
  logic      rx_done;
  byte_t     rx_data, rx_hold;

  byte_t     io_byte, io_byte_q;  // I/O read value, captured at request
  logic      rd_io_q;
  rtype_t    rd_type_q;
  logic [1:0] rd_lane_q;
  data_t     rd_ext, data_hold;

  function automatic data_t ext_byte(byte_t b, logic sgn);
    return {{24{sgn & b[7]}}, b};
  endfunction

  function automatic data_t ext_half(logic [15:0] h, logic sgn);
    return {{16{sgn & h[15]}}, h};
  endfunction

  // address decode
  assign is_led      = (address == `RAMIO_ADDR_LED);
  assign is_uart_out = (address == `RAMIO_ADDR_UART_OUT);
  assign is_uart_in  = (address == `RAMIO_ADDR_UART_IN);
  assign is_io       = is_led | is_uart_out | is_uart_in;

  // I/O registers only react to byte accesses
  assign wr_led      = enable && is_led && write_type == SZ_BYTE;
  assign wr_uart_out = enable && is_uart_out && write_type == SZ_BYTE;
  assign rd_uart_in  = enable && is_uart_in && read_type[1:0] == SZ_BYTE;
  assign rd_fire     = enable && read_type != '0;

  assign ram_en   = enable && !is_io;
  assign ram_addr = address[`RAMIO_RAM_AW+1:2];

  // write lane steering, data replicated so be alone picks the lanes
  always_comb begin
    ram_be    = '0;
    ram_wdata = '0;
    if (!is_io) begin
      case (write_type)
        SZ_BYTE: begin
          ram_be    = be_t'(4'b0001 << address[1:0]);
          ram_wdata = {4{data_in[7:0]}};
        end
        SZ_HALF: if (!address[0]) begin  // lane 1 and 3 misaligned
          ram_be    = address[1] ? 4'b1100 : 4'b0011;
          ram_wdata = {2{data_in[15:0]}};
        end
        SZ_WORD: if (address[1:0] == 2'd0) begin
          ram_be    = 4'b1111;
          ram_wdata = data_in;
        end
        default: ;  // pure read
      endcase
    end
  end

  // byte seen by an I/O read, LED reads zero
  always_comb begin
    io_byte = '0;
    if (is_uart_out && tx_busy) io_byte = tx_sending;
    else if (is_uart_in)        io_byte = rx_hold;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out_ready <= 1'b0;
      rd_io_q        <= 1'b0;
      rd_type_q      <= '0;
      rd_lane_q      <= '0;
      led            <= '1;  // LEDs off
      tx_sending     <= '0;
      rx_hold        <= '0;
    end else begin
      data_out_ready <= rd_fire;  // one pulse per read, latency 1
      if (rd_fire) begin
        rd_io_q   <= is_io;
        rd_type_q <= read_type;
        rd_lane_q <= address[1:0];
      end
      if (wr_led) led <= data_in[3:0];
      // follows the byte uart_tx accepts, cleared once idle
      if (!tx_busy) tx_sending <= wr_uart_out ? data_in[7:0] : '0;
      // new byte wins over clear-on-read
      if (rx_done)         rx_hold <= rx_data;
      else if (rd_uart_in) rx_hold <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire)        io_byte_q <= io_byte;
    if (data_out_ready) data_hold <= rd_ext;  // keeps data_out until next read
  end

  // extend RAM word or I/O byte per registered request
  always_comb begin
    rd_ext = '0;
    if (rd_io_q) begin
      if (rd_type_q[1:0] == SZ_BYTE) rd_ext = ext_byte(io_byte_q, rd_type_q[2]);
    end else begin
      case (rd_type_q[1:0])
        SZ_BYTE: rd_ext = ext_byte(ram_rdata[8*rd_lane_q +: 8], rd_type_q[2]);
        SZ_HALF: if (!rd_lane_q[0]) begin
          rd_ext = ext_half(ram_rdata[16*rd_lane_q[1] +: 16], rd_type_q[2]);
        end
        SZ_WORD: if (rd_lane_q == 2'd0) rd_ext = ram_rdata;
        default: ;
      endcase
    end
  end

  assign data_out = data_out_ready ? rd_ext : data_hold;

  assign tx_start = wr_uart_out;
  assign tx_data  = data_in[7:0];

  word_ram #(
    .AW(`RAMIO_RAM_AW)
  ) u_ram (
    .clk  (clk),
    .en   (ram_en),
    .be   (ram_be),
    .addr (ram_addr),
    .wdata(ram_wdata),
    .rdata(ram_rdata)
  );

  uart_tx #(
    .CLKS_PER_BIT(`RAMIO_CLKS_PER_BIT)
  ) u_tx (
    .clk  (clk),
    .rst_n(rst_n),
    .start(tx_start),
    .data (tx_data),
    .tx   (uart_tx),
    .busy (tx_busy)
  );

  uart_rx #(
    .CLKS_PER_BIT(`RAMIO_CLKS_PER_BIT)
  ) u_rx (
    .clk  (clk),
    .rst_n(rst_n),
    .rx   (uart_rx),
    .data (rx_data),
    .done (rx_done)
  );

endmodule

`default_nettype wire

/* hw/ramio_params.svh */
/* ramio parameters
   bus widths, RAM depth, I/O register map and UART bit timing */
`ifndef RAMIO_PARAMS_SVH
`define RAMIO_PARAMS_SVH

// byte address and data word widths
`define RAMIO_ADDR_W 32
`define RAMIO_DATA_W 32

// RAM word address bits, 1024 words
`define RAMIO_RAM_AW 10

// I/O registers sit at the very top of the address space
`define RAMIO_ADDR_LED      32'hFFFF_FFFF
`define RAMIO_ADDR_UART_OUT 32'hFFFF_FFFE
`define RAMIO_ADDR_UART_IN  32'hFFFF_FFFD

// clocks per UART bit
// kept small so a frame takes 160 clocks in simulation
`define RAMIO_CLKS_PER_BIT 16

`endif

/* hw/ramio_pkg.sv */
/* ramio_pkg
   shared types of the load/store port: bus vectors, access codes, UART FSM states */
`default_nettype none

`include "ramio_params.svh"

package ramio_pkg;

  typedef logic [`RAMIO_ADDR_W-1:0] addr_t;   // byte address
  typedef logic [`RAMIO_DATA_W-1:0] data_t;   // data word
  typedef logic [7:0]               byte_t;   // one UART character

  // access size: 0 none, 1 byte, 2 half, 3 word
  typedef logic [1:0] wtype_t;
  // [1:0] size as wtype_t, [2] sign extend
  typedef logic [2:0] rtype_t;

  typedef logic [`RAMIO_DATA_W/8-1:0] be_t;   // one enable per byte lane
  typedef logic [3:0]                 led_t;
  typedef logic [`RAMIO_RAM_AW-1:0]   ram_addr_t;   // word address into RAM

  // shared by tx and rx
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
/* uart_rx
   8N1 deserializer, mid-bit sampling, one-cycle done strobe per good frame */
`default_nettype none

`include "ramio_params.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `RAMIO_CLKS_PER_BIT
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rx,
  output ramio_pkg::byte_t data,
  output logic             done
);
  import ramio_pkg::*;

  localparam int HALF     = CLKS_PER_BIT / 2;
  localparam int STOP_END = CLKS_PER_BIT - 1 + HALF;  // stop sample plus half bit
  localparam int CW       = $clog2(STOP_END + 1);

  logic          rx_meta;
  logic          rx_sync;
  uart_state_e   state;
  logic [CW-1:0] cnt;
  logic [2:0]    bit_idx;
  logic          stop_ok;   // stop bit seen high
  logic          mid_bit;   // center of a full bit

  assign mid_bit = (cnt == CW'(CLKS_PER_BIT - 1));

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      stop_ok <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      cnt  <= cnt + CW'(1);
      case (state)
        IDLE: begin
          cnt <= '0;
          if (!rx_sync) state <= START;  // falling edge
        end
        START: if (cnt == CW'(HALF - 1)) begin
          cnt     <= '0;
          bit_idx <= '0;
          state   <= rx_sync ? IDLE : DATA;  // glitch if high at mid start
        end
        DATA: if (mid_bit) begin
          cnt     <= '0;
          bit_idx <= bit_idx + 3'd1;
          if (bit_idx == 3'd7) state <= STOP;
        end
        STOP: begin
          if (mid_bit) stop_ok <= rx_sync;
          if (cnt == CW'(STOP_END)) begin
            done  <= stop_ok;  // framing error drops the byte
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // shift register doubles as output, valid with done
  always_ff @(posedge clk) begin
    if (state == DATA && mid_bit) begin
      data <= {rx_sync, data[7:1]};
    end
  end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
/* uart_tx
   8N1 serializer, latches a byte on start and shifts it out LSB first */
`default_nettype none

`include "ramio_params.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `RAMIO_CLKS_PER_BIT
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  ramio_pkg::byte_t data,
  output logic             tx,
  output logic             busy
);
  import ramio_pkg::*;

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  uart_state_e   state;
  logic [CW-1:0] cnt;      // clocks into current bit
  logic [2:0]    bit_idx;  // data bit being sent
  logic          bit_end;  // last clock of a bit period
  byte_t         shreg;

  assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= bit_end ? '0 : cnt + CW'(1);  // free runs outside idle
      case (state)
        IDLE: begin
          cnt <= '0;
          if (start) state <= START;  // start bit from next clock
        end
        START: if (bit_end) begin
          state   <= DATA;
          bit_idx <= '0;
        end
        DATA: if (bit_end) begin
          bit_idx <= bit_idx + 3'd1;
          if (bit_idx == 3'd7) state <= STOP;
        end
        STOP: if (bit_end) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // payload, loaded on accepted start, shifted at each data bit end
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      shreg <= data;
    end else if (state == DATA && bit_end) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

  always_comb begin
    case (state)
      START:   tx = 1'b0;
      DATA:    tx = shreg[0];  // LSB first
      default: tx = 1'b1;      // idle and stop are mark
    endcase
  end

  assign busy = (state != IDLE);  // start while busy is dropped in IDLE check

endmodule

`default_nettype wire

/* hw/word_ram.sv */
/* word_ram
   single-port word RAM with per-byte write enables and a registered read port */
`default_nettype none

`include "ramio_params.svh"

module word_ram #(
  parameter int AW = `RAMIO_RAM_AW
) (
  input  logic             clk,
  input  logic             en,
  input  ramio_pkg::be_t   be,
  input  logic [AW-1:0]    addr,
  input  ramio_pkg::data_t wdata,
  output ramio_pkg::data_t rdata
);
  import ramio_pkg::*;

  localparam int DEPTH = 1 << AW;
  localparam int LANES = $bits(be_t);

  data_t mem [DEPTH];  // no init, contents undefined until written

  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];  // old word, write lands after this read
      for (int i = 0; i < LANES; i++) begin
        if (be[i]) begin
          mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire
